/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = tbGbCpuCore
RTL_TOP   = gbCpuCore
FILELIST  = gbCpuCore.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* gbCpuCore.f */
+incdir+testbench
verilog/cpuTypesPkg.sv
verilog/microcodePkg.sv
verilog/microcodeRom.sv
verilog/flowSequencer.sv
verilog/registerFile.sv
verilog/aluFlags.sv
verilog/gbCpuCore.sv
testbench/tbGbCpuCore.sv

/* testbench/programTable.svh */
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// Program bytes load at resetPc, unused bytes stay NOP
typedef struct packed {
  logic [63:0] name;      // Eight characters
  byteT [0:23] prog;
  logic [2:0]  nWrites;
  addrT [0:3]  wrAddr;
  byteT [0:3]  wrData;
  logic [7:0]  retires;   // HALT included
} progEntryT;

localparam int numTests = 7;

// HL points into C0xx, results land there through LD (HL),r
localparam progEntryT programTable [numTests] = '{
  '{"ldImm   ",
    '{8'h26, 8'hC0, 8'h2E, 8'h00, 8'h06, 8'h12, 8'h70, 8'h2E, 8'h01, 8'h3E, 8'h5A, 8'h77,
      8'h76, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    3'd2, '{16'hC000, 16'hC001, 16'h0000, 16'h0000},
    '{8'h12, 8'h5A, 8'h00, 8'h00}, 8'd8},
  '{"ldMove  ",
    '{8'h26, 8'hC0, 8'h2E, 8'h10, 8'h3E, 8'h3C, 8'h47, 8'h50, 8'h72, 8'h5E, 8'h2E, 8'h11,
      8'h73, 8'h76, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    3'd2, '{16'hC010, 16'hC011, 16'h0000, 16'h0000},
    '{8'h3C, 8'h3C, 8'h00, 8'h00}, 8'd10},
  '{"addSub  ",   // 3A+C5 and 3A-C5
    '{8'h26, 8'hC0, 8'h2E, 8'h20, 8'h06, 8'hC5, 8'h3E, 8'h3A, 8'h80, 8'h77, 8'h2C, 8'h3E,
      8'h3A, 8'h90, 8'h77, 8'h76, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    3'd2, '{16'hC020, 16'hC021, 16'h0000, 16'h0000},
    '{8'hFF, 8'h75, 8'h00, 8'h00}, 8'd11},
  '{"logicOps",
    '{8'h26, 8'hC0, 8'h2E, 8'h30, 8'h06, 8'hC5, 8'h3E, 8'h3A, 8'hA0, 8'h77, 8'h2C, 8'h3E,
      8'h3A, 8'hB0, 8'h77, 8'h2C, 8'h3E, 8'h3C, 8'hA8, 8'h77, 8'h76, 8'h00, 8'h00, 8'h00},
    3'd3, '{16'hC030, 16'hC031, 16'hC032, 16'h0000},
    '{8'h00, 8'hFF, 8'hF9, 8'h00}, 8'd15},
  '{"jpCReset",   // C=1 out of reset, EE marks the wrong path
    '{8'h26, 8'hC0, 8'h2E, 8'h40, 8'hDA, 8'h0B, 8'h01, 8'h3E, 8'hEE, 8'h77, 8'h76, 8'h3E,
      8'h11, 8'h77, 8'h76, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    3'd1, '{16'hC040, 16'h0000, 16'h0000, 16'h0000},
    '{8'h11, 8'h00, 8'h00, 8'h00}, 8'd6},
  '{"jpCond  ",   // SUB A gives Z=1 C=0
    '{8'h26, 8'hC0, 8'h2E, 8'h50, 8'h97, 8'hC2, 8'h12, 8'h01, 8'hDA, 8'h12, 8'h01, 8'hD2,
      8'h0F, 8'h01, 8'h76, 8'hCA, 8'h13, 8'h01, 8'h76, 8'h3E, 8'hA5, 8'h77, 8'h76, 8'h00},
    3'd1, '{16'hC050, 16'h0000, 16'h0000, 16'h0000},
    '{8'hA5, 8'h00, 8'h00, 8'h00}, 8'd10},
  '{"incDec  ",   // Carry from FF+01 must survive INC and DEC
    '{8'h26, 8'hC0, 8'h2E, 8'h60, 8'h3E, 8'hFF, 8'h06, 8'h01, 8'h80, 8'h3C, 8'h77, 8'h2C,
      8'h3D, 8'h3D, 8'h77, 8'hDA, 8'h13, 8'h01, 8'h76, 8'h2C, 8'h3E, 8'h5C, 8'h77, 8'h76},
    3'd3, '{16'hC060, 16'hC061, 16'hC062, 16'h0000},
    '{8'h01, 8'hFF, 8'h5C, 8'h00}, 8'd16}
};

`endif

/* testbench/tbGbCpuCore.sv */
`default_nettype none

module tbGbCpuCore
  import cpuTypesPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  `include "programTable.svh"

  localparam addrT tbResetPc   = 16'h0100;
  localparam int   haltTimeout = 2000;

  logic iClock;
  logic rstN;
  byteT memRdData;
  addrT memAddr;
  byteT memWrData;
  logic memRead;
  logic memWe;
  byteT opcode;
  logic retire;
  logic halted;

  byteT mem [65536];
  addrT wrAddrQ [$];
  byteT wrDataQ [$];
  int   retireCount;
  addrT firstReadAddr;
  logic firstReadSeen;
  logic fetchPending;
  byteT fetchedOpcode;
  int   testErrors;
  int   errorCount;
  int   failedTests;

  assign memRdData = mem[memAddr];   // Asynchronous read

  gbCpuCore #(
    .resetPc (tbResetPc)
  ) gbCpuCore_inst (
    .iClock    (iClock),
    .rstN      (rstN),
    .memRdData (memRdData),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .memRead   (memRead),
    .memWe     (memWe),
    .opcode    (opcode),
    .retire    (retire),
    .halted    (halted)
  );

  initial
  begin
    iClock = 1'b0;
    forever #10 iClock = ~iClock;
  end

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------
  task automatic checkByte(input string what, input byteT got, input byteT exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkAddr(input string what, input addrT got, input addrT exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkCount(input string what, input int got, input int exp);
    if (got != exp)
    begin
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, what, got, exp);
      testErrors++;
    end
  endtask

  task automatic reportProblem(input string msg);
    $display("%0t: %s", $time, msg);
    testErrors++;
  endtask

  // One clock edge of the memory model and the bus monitor
  task automatic sampleCycle();
    @(posedge iClock);
    if (memWe)
    begin
      mem[memAddr] <= memWrData;
      wrAddrQ.push_back(memAddr);
      wrDataQ.push_back(memWrData);
    end
    if (memRead && !firstReadSeen)
    begin
      firstReadAddr = memAddr;
      firstReadSeen = 1'b1;
    end
    if (memRead && fetchPending)
    begin
      fetchedOpcode = memRdData;   // First read of a flow is the fetch
      fetchPending  = 1'b0;
    end
    if (retire)
    begin
      retireCount++;
      checkByte("opcode", opcode, fetchedOpcode);
      fetchPending = 1'b1;
    end
  endtask

  task automatic runTest(input int idx);
    progEntryT entry;
    int        cycles;
    logic      done;
    entry      = programTable[idx];
    testErrors = 0;
    @(posedge iClock);
    #1 rstN = 1'b0;
    for (int a = 0; a < 65536; a++)
      mem[a] <= 8'h00;
    for (int b = 0; b < 24; b++)
      mem[addrT'(tbResetPc + b)] <= entry.prog[b];
    wrAddrQ.delete();
    wrDataQ.delete();
    retireCount   = 0;
    firstReadSeen = 1'b0;
    firstReadAddr = '0;
    fetchPending  = 1'b1;
    fetchedOpcode = '0;
    repeat (5) @(posedge iClock);
    #1;
    if (memWe || memRead || retire || halted)
      reportProblem("bus strobes not quiet during reset");
    rstN = 1'b1;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < haltTimeout)
    begin
      sampleCycle();
      cycles++;
      if (halted)
        done = 1'b1;
    end
    if (!done)
      reportProblem($sformatf("halted never came within %0d cycles", haltTimeout));
    else
    begin
      if (!firstReadSeen)
        reportProblem("no memory read seen after reset");
      checkAddr("memAddr", firstReadAddr, tbResetPc);
      checkCount("retire", retireCount, int'(entry.retires));
      checkCount("memWe", wrAddrQ.size(), int'(entry.nWrites));
      for (int w = 0; w < int'(entry.nWrites) && w < wrAddrQ.size(); w++)
      begin
        checkAddr("memAddr", wrAddrQ[w], entry.wrAddr[w]);
        checkByte("memWrData", wrDataQ[w], entry.wrData[w]);
        checkByte("mem", mem[entry.wrAddr[w]], entry.wrData[w]);
      end
      // Core must stay parked
      repeat (4)
      begin
        sampleCycle();
        if (!halted)
          reportProblem("halted dropped after HALT");
      end
      checkCount("retire", retireCount, int'(entry.retires));
    end
    $display("test %0d %s: %s", idx, entry.name, (testErrors == 0) ? "passed" : "failed");
    if (testErrors != 0)
      failedTests++;
    errorCount += testErrors;
  endtask

  initial
  begin
    rstN        = 1'b0;
    errorCount  = 0;
    failedTests = 0;
    testErrors  = 0;
    for (int t = 0; t < numTests; t++)
      runTest(t);
    $display("tests %0d, failed tests %0d, failed checks %0d", numTests, failedTests, errorCount);
    if (errorCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/aluFlags.sv */
`default_nettype none

module aluFlags
  import cpuTypesPkg::*;
  import microcodePkg::*;
(
  input  logic  iClock,
  input  logic  rstN,
  input  uopT   uop,
  input  byteT  opcode,
  input  logic  flowActive,
  input  byteT  srcData,
  input  byteT  regA,
  input  byteT  memRdData,
  output flagsT flags,
  output logic  wrEn,
  output byteT  wrData
);

  logic [8:0] addFull;
  logic [8:0] subFull;
  logic [4:0] addHalf;
  logic [4:0] subHalf;
  byteT       result;
  flagsT      nextFlags;

  assign addFull = {1'b0, regA} + {1'b0, srcData};
  assign subFull = {1'b0, regA} - {1'b0, srcData};
  assign addHalf = {1'b0, regA[3:0]} + {1'b0, srcData[3:0]};
  assign subHalf = {1'b0, regA[3:0]} - {1'b0, srcData[3:0]};   // Bit 4 is the borrow

  always_comb
  begin
    result    = srcData;   // Register move
    nextFlags = flags;
    if (uop.cmd == cmdStoreMem)
      result = memRdData;
    else if (uop.cmd == cmdAluOp)
    begin
      if (opcode[7:6] == 2'b00)
      begin
        // INC and DEC leave C alone
        if (opcode[0])
        begin
          result      = srcData - 8'd1;
          nextFlags.n = 1'b1;
          nextFlags.h = (result[3:0] == 4'hF);
        end
        else
        begin
          result      = srcData + 8'd1;
          nextFlags.n = 1'b0;
          nextFlags.h = (result[3:0] == 4'h0);
        end
      end
      else
      begin
        nextFlags.n = 1'b0;
        nextFlags.c = 1'b0;
        nextFlags.h = 1'b0;
        case (opcode[5:3])
          3'b000:
          begin
            result      = addFull[7:0];
            nextFlags.h = addHalf[4];
            nextFlags.c = addFull[8];
          end
          3'b010:
          begin
            result      = subFull[7:0];
            nextFlags.n = 1'b1;
            nextFlags.h = subHalf[4];
            nextFlags.c = subFull[8];
          end
          3'b100:
          begin
            result      = regA & srcData;
            nextFlags.h = 1'b1;
          end
          3'b101:  result = regA ^ srcData;
          default: result = regA | srcData;   // OR, other codes never get here
        endcase
      end
      nextFlags.z = (result == 8'h00);
    end
  end

  assign wrData = result;
  assign wrEn   = flowActive && (uop.cmd == cmdStoreMem || uop.cmd == cmdLdRR ||
                  uop.cmd == cmdAluOp);

  always_ff @(posedge iClock)
  begin
    if (!rstN)
      flags <= flagsReset;
    else if (flowActive && uop.cmd == cmdAluOp)
      flags <= nextFlags;
  end

endmodule

`default_nettype wire

/* verilog/cpuTypesPkg.sv */
`default_nettype none

// Widths and encodings shared by every block of the core
package cpuTypesPkg;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;

  // Values 0..7 follow the 3-bit r field of the opcode
  typedef enum logic [4:0] {
    regB    = 5'd0,
    regC    = 5'd1,
    regD    = 5'd2,
    regE    = 5'd3,
    regH    = 5'd4,
    regL    = 5'd5,
    regHL   = 5'd6,   // (HL) in the opcode field
    regA    = 5'd7,
    regPc   = 5'd8,
    regX16  = 5'd9,
    regNull = 5'd10
  } regSelE;

  // Flags register
  typedef struct packed {
    logic       z;
    logic       n;
    logic       h;
    logic       c;
    logic [3:0] zeroBits;   // Always zero
  } flagsT;

  localparam flagsT flagsReset = 8'hB0;   // Z=1 N=0 H=1 C=1

endpackage

`default_nettype wire

/* verilog/flowSequencer.sv */
`default_nettype none

module flowSequencer
  import cpuTypesPkg::*;
  import microcodePkg::*;
(
  input  logic  iClock,
  input  logic  rstN,
  input  byteT  memRdData,
  input  flagsT flags,
  output uopT   uop,
  output byteT  opcode,
  output logic  flowActive,
  output logic  flowStart,
  output logic  retire,
  output logic  halted
);

  typedef enum logic [1:0] {
    afterReset,
    startFlow,
    runFlow,
    endFlow
  } flowStateE;

  flowStateE state;
  flowStateE nextState;
  uPcT       uPc;
  flowIdxT   flowIdx;
  logic      eofHit;

  microcodeRom microcodeRom_inst (
    .opcode  (memRdData),   // Lookup on the byte being fetched
    .flowIdx (flowIdx),
    .uPc     (uPc),
    .uop     (uop)
  );

  assign flowStart  = (state == startFlow);
  assign flowActive = (state == runFlow);
  assign retire     = flowActive && eofHit;

  always_comb
  begin
    case (uop.eofCond)
      eofAlways: eofHit = 1'b1;
      eofC:      eofHit = flags.c;
      eofNc:     eofHit = !flags.c;
      eofZ:      eofHit = flags.z;
      eofNz:     eofHit = !flags.z;
      default:   eofHit = 1'b0;
    endcase
  end

  always_comb
  begin
    nextState = state;
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:    if (eofHit) nextState = endFlow;
      endFlow:    if (!halted) nextState = startFlow;   // Parked once halted
      default:    nextState = afterReset;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      state  <= afterReset;
      uPc    <= '0;
      halted <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (flowStart)
        uPc <= flowIdx;
      else if (flowActive && uop.cmd != cmdHalt)
        uPc <= uPc + 7'd1;
      if (flowActive && uop.cmd == cmdHalt)
        halted <= 1'b1;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (flowStart)
      opcode <= memRdData;
  end

  // The halt micro-op must close its flow or the core never parks
  haltEndsFlow: assert property (@(posedge iClock) disable iff (!rstN)
    flowActive && uop.cmd == cmdHalt |-> retire)
    else $error("halt micro-op does not end its flow");

endmodule

`default_nettype wire

/* verilog/gbCpuCore.sv */
`default_nettype none

module gbCpuCore
  import cpuTypesPkg::*;
  import microcodePkg::*;
#(
  parameter addrT resetPc = 16'h0000
)
(
  input  logic iClock,
  input  logic rstN,
  input  byteT memRdData,
  output addrT memAddr,
  output byteT memWrData,
  output logic memRead,
  output logic memWe,
  output byteT opcode,
  output logic retire,
  output logic halted
);

  uopT   uop;
  flagsT flags;
  logic  flowActive;
  logic  flowStart;
  logic  wrEn;
  byteT  wrData;
  byteT  srcData;
  byteT  accA;

  //--------------------------------------------------------------------
  // Sequencer, datapath and flags
  //--------------------------------------------------------------------
  flowSequencer flowSequencer_inst (
    .iClock     (iClock),
    .rstN       (rstN),
    .memRdData  (memRdData),
    .flags      (flags),
    .uop        (uop),
    .opcode     (opcode),
    .flowActive (flowActive),
    .flowStart  (flowStart),
    .retire     (retire),
    .halted     (halted)
  );

  registerFile #(
    .resetPc (resetPc)
  ) registerFile_inst (
    .iClock     (iClock),
    .rstN       (rstN),
    .uop        (uop),
    .opcode     (opcode),
    .flowActive (flowActive),
    .flowStart  (flowStart),
    .wrEn       (wrEn),
    .wrData     (wrData),
    .memRdData  (memRdData),
    .srcData    (srcData),
    .regA       (accA),
    .memAddr    (memAddr),
    .memWrData  (memWrData),
    .memRead    (memRead),
    .memWe      (memWe)
  );

  aluFlags aluFlags_inst (
    .iClock     (iClock),
    .rstN       (rstN),
    .uop        (uop),
    .opcode     (opcode),
    .flowActive (flowActive),
    .srcData    (srcData),
    .regA       (accA),
    .memRdData  (memRdData),
    .flags      (flags),
    .wrEn       (wrEn),
    .wrData     (wrData)
  );

endmodule

`default_nettype wire

/* verilog/microcodePkg.sv */
`default_nettype none

package microcodePkg;

  import cpuTypesPkg::*;

  typedef logic [6:0] uPcT;
  typedef logic [6:0] flowIdxT;

  typedef enum logic [4:0] {
    cmdNop        = 5'd0,
    cmdSetMemAddr = 5'd1,   // Latch address select
    cmdStoreMem   = 5'd2,   // Register gets read data
    cmdWriteMem   = 5'd3,
    cmdIncPcOnly  = 5'd4,
    cmdAluOp      = 5'd5,   // Operation from latched opcode
    cmdLdRR       = 5'd6,
    cmdLoadX16Lo  = 5'd7,
    cmdLoadX16Hi  = 5'd8,
    cmdJumpX16    = 5'd9,
    cmdHalt       = 5'd10
  } uopCmdE;

  typedef enum logic [2:0] {
    eofNone   = 3'd0,
    eofAlways = 3'd1,
    eofC      = 3'd2,
    eofNc     = 3'd3,
    eofZ      = 3'd4,
    eofNz     = 3'd5
  } eofCondE;

  typedef struct packed {
    logic       incPc;
    eofCondE    eofCond;
    uopCmdE     cmd;
    regSelE     src;
    logic [2:0] dst;
  } uopT;

  // Destination codes
  localparam logic [2:0] dstNone = 3'd0;
  localparam logic [2:0] dstOpR  = 3'd1;   // Opcode bits 5:3
  localparam logic [2:0] dstA    = 3'd2;

  // Flow start addresses in the micro-op ROM
  localparam flowIdxT flowNop    = 7'd0;
  localparam flowIdxT flowHalt   = 7'd1;
  localparam flowIdxT flowLdRN   = 7'd2;
  localparam flowIdxT flowLdRR   = 7'd4;
  localparam flowIdxT flowLdRHl  = 7'd5;
  localparam flowIdxT flowLdHlR  = 7'd8;
  localparam flowIdxT flowAlu    = 7'd11;
  localparam flowIdxT flowIncDec = 7'd12;
  localparam flowIdxT flowJp     = 7'd13;
  localparam flowIdxT flowJpNz   = 7'd17;
  localparam flowIdxT flowJpZ    = 7'd21;
  localparam flowIdxT flowJpNc   = 7'd25;
  localparam flowIdxT flowJpC    = 7'd29;

endpackage

`default_nettype wire

/* verilog/microcodeRom.sv */
`default_nettype none

module microcodeRom
  import cpuTypesPkg::*;
  import microcodePkg::*;
(
  input  byteT    opcode,
  output flowIdxT flowIdx,
  input  uPcT     uPc,
  output uopT     uop
);

  function automatic uopT makeUop(input logic inc, input eofCondE eof, input uopCmdE op,
                                  input regSelE src, input logic [2:0] dst);
    return '{incPc: inc, eofCond: eof, cmd: op, src: src, dst: dst};
  endfunction

  // Opcode to flow start, first match wins
  always_comb
  begin
    flowIdx = flowNop;
    casez (opcode)
      8'h34, 8'h35, 8'h36: flowIdx = flowNop;   // (HL) forms not kept
      8'h76:               flowIdx = flowHalt;
      8'b00???110:         flowIdx = flowLdRN;
      8'b00???10?:         flowIdx = flowIncDec;
      8'b01110???:         flowIdx = flowLdHlR;
      8'b01???110:         flowIdx = flowLdRHl;
      8'b01??????:         flowIdx = flowLdRR;
      8'b10???110:         flowIdx = flowNop;
      8'b10000???, 8'b10010???, 8'b10100???, 8'b10101???, 8'b10110???:
        flowIdx = flowAlu;
      8'hC3:               flowIdx = flowJp;
      8'hC2:               flowIdx = flowJpNz;
      8'hCA:               flowIdx = flowJpZ;
      8'hD2:               flowIdx = flowJpNc;
      8'hDA:               flowIdx = flowJpC;
      default:             flowIdx = flowNop;
    endcase
  end

  always_comb
  begin
    case (uPc)
      flowNop:          uop = makeUop(1'b0, eofAlways, cmdIncPcOnly, regNull, dstNone);
      flowHalt:         uop = makeUop(1'b0, eofAlways, cmdHalt, regNull, dstNone);
      flowLdRN:         uop = makeUop(1'b0, eofNone, cmdIncPcOnly, regNull, dstNone);
      flowLdRN + 7'd1:  uop = makeUop(1'b1, eofAlways, cmdStoreMem, regNull, dstOpR);
      flowLdRR:         uop = makeUop(1'b1, eofAlways, cmdLdRR, regNull, dstOpR);
      // Address switches to HL, then back to PC
      flowLdRHl:        uop = makeUop(1'b1, eofNone, cmdSetMemAddr, regHL, dstNone);
      flowLdRHl + 7'd1: uop = makeUop(1'b0, eofNone, cmdStoreMem, regNull, dstOpR);
      flowLdRHl + 7'd2: uop = makeUop(1'b0, eofAlways, cmdSetMemAddr, regPc, dstNone);
      flowLdHlR:        uop = makeUop(1'b1, eofNone, cmdSetMemAddr, regHL, dstNone);
      flowLdHlR + 7'd1: uop = makeUop(1'b0, eofNone, cmdWriteMem, regNull, dstNone);
      flowLdHlR + 7'd2: uop = makeUop(1'b0, eofAlways, cmdSetMemAddr, regPc, dstNone);
      //----------------------------------------------------------------------
      // ALU flows
      //----------------------------------------------------------------------
      flowAlu:          uop = makeUop(1'b1, eofAlways, cmdAluOp, regNull, dstA);
      flowIncDec:       uop = makeUop(1'b1, eofAlways, cmdAluOp, regNull, dstOpR);
      //----------------------------------------------------------------------
      flowJp:           uop = makeUop(1'b0, eofNone, cmdIncPcOnly, regNull, dstNone);
      flowJp + 7'd1:    uop = makeUop(1'b1, eofNone, cmdLoadX16Lo, regNull, dstNone);
      flowJp + 7'd2:    uop = makeUop(1'b1, eofNone, cmdLoadX16Hi, regNull, dstNone);
      flowJp + 7'd3:    uop = makeUop(1'b0, eofAlways, cmdJumpX16, regNull, dstNone);
      // Conditional jumps end early when not taken
      flowJpNz:         uop = makeUop(1'b0, eofNone, cmdIncPcOnly, regNull, dstNone);
      flowJpNz + 7'd1:  uop = makeUop(1'b1, eofNone, cmdLoadX16Lo, regNull, dstNone);
      flowJpNz + 7'd2:  uop = makeUop(1'b1, eofZ, cmdLoadX16Hi, regNull, dstNone);
      flowJpNz + 7'd3:  uop = makeUop(1'b0, eofAlways, cmdJumpX16, regNull, dstNone);
      flowJpZ:          uop = makeUop(1'b0, eofNone, cmdIncPcOnly, regNull, dstNone);
      flowJpZ + 7'd1:   uop = makeUop(1'b1, eofNone, cmdLoadX16Lo, regNull, dstNone);
      flowJpZ + 7'd2:   uop = makeUop(1'b1, eofNz, cmdLoadX16Hi, regNull, dstNone);
      flowJpZ + 7'd3:   uop = makeUop(1'b0, eofAlways, cmdJumpX16, regNull, dstNone);
      flowJpNc:         uop = makeUop(1'b0, eofNone, cmdIncPcOnly, regNull, dstNone);
      flowJpNc + 7'd1:  uop = makeUop(1'b1, eofNone, cmdLoadX16Lo, regNull, dstNone);
      flowJpNc + 7'd2:  uop = makeUop(1'b1, eofC, cmdLoadX16Hi, regNull, dstNone);
      flowJpNc + 7'd3:  uop = makeUop(1'b0, eofAlways, cmdJumpX16, regNull, dstNone);
      flowJpC:          uop = makeUop(1'b0, eofNone, cmdIncPcOnly, regNull, dstNone);
      flowJpC + 7'd1:   uop = makeUop(1'b1, eofNone, cmdLoadX16Lo, regNull, dstNone);
      flowJpC + 7'd2:   uop = makeUop(1'b1, eofNc, cmdLoadX16Hi, regNull, dstNone);
      flowJpC + 7'd3:   uop = makeUop(1'b0, eofAlways, cmdJumpX16, regNull, dstNone);
      default:          uop = makeUop(1'b0, eofAlways, cmdNop, regNull, dstNone);
    endcase
  end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`default_nettype none

module registerFile
  import cpuTypesPkg::*;
  import microcodePkg::*;
#(
  parameter addrT resetPc = 16'h0000
)
(
  input  logic  iClock,
  input  logic  rstN,
  input  uopT   uop,
  input  byteT  opcode,
  input  logic  flowActive,
  input  logic  flowStart,
  input  logic  wrEn,
  input  byteT  wrData,
  input  byteT  memRdData,
  output byteT  srcData,
  output byteT  regA,
  output addrT  memAddr,
  output byteT  memWrData,
  output logic  memRead,
  output logic  memWe
);

  byteT       gpr [8];   // B C D E H L - A, slot 6 is (HL)
  addrT       pc;
  addrT       x16;
  regSelE     addrSel;
  regSelE     srcSel;
  logic [2:0] wrSel;

  // Source register, opcode fields override the uop for r operands
  always_comb
  begin
    srcSel = uop.src;
    case (uop.cmd)
      cmdLdRR, cmdWriteMem: srcSel = regSelE'({2'b00, opcode[2:0]});
      cmdAluOp:
      begin
        if (opcode[7:6] == 2'b00)
          srcSel = regSelE'({2'b00, opcode[5:3]});   // INC/DEC
        else
          srcSel = regSelE'({2'b00, opcode[2:0]});
      end
      default: ;
    endcase
  end

  assign srcData = (srcSel <= cpuTypesPkg::regA && srcSel != regHL) ? gpr[srcSel[2:0]] : 8'h00;
  assign regA    = gpr[7];

  always_comb
  begin
    wrSel = opcode[5:3];
    if (uop.dst == dstA)
      wrSel = 3'd7;
  end

  assign memAddr   = (addrSel == regHL) ? {gpr[4], gpr[5]} : pc;
  assign memWrData = srcData;
  assign memWe     = flowActive && uop.cmd == cmdWriteMem;
  assign memRead   = flowStart || (flowActive && (uop.cmd == cmdStoreMem ||
                     uop.cmd == cmdLoadX16Lo || uop.cmd == cmdLoadX16Hi));

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        gpr[i] <= '0;
      pc      <= resetPc;
      addrSel <= regPc;
    end
    else if (flowActive)
    begin
      if (wrEn && uop.dst != dstNone)
        gpr[wrSel] <= wrData;
      if (uop.cmd == cmdSetMemAddr)
        addrSel <= uop.src;
      if (uop.cmd == cmdJumpX16)
        pc <= x16;
      else if (uop.incPc || uop.cmd == cmdIncPcOnly)
        pc <= pc + 16'd1;
    end
  end

  // Jump target, low byte first
  always_ff @(posedge iClock)
  begin
    if (flowActive && uop.cmd == cmdLoadX16Lo)
      x16[7:0] <= memRdData;
    if (flowActive && uop.cmd == cmdLoadX16Hi)
      x16[15:8] <= memRdData;
  end

  memWeAfterAddr: assert property (@(posedge iClock) disable iff (!rstN)
    memWe |-> $past(flowActive) && $past(uop.cmd) == cmdSetMemAddr)
    else $error("memory write without a preceding address select");

endmodule

`default_nettype wire
